// ==== Makefile ====
.PHONY: run clean

obj_dir/Vpredecode_tb: src.f $(shell cat src.f)
	verilator --binary --timing --assert -f src.f --top-module predecode_tb -o Vpredecode_tb

run: obj_dir/Vpredecode_tb
	./obj_dir/Vpredecode_tb | tee sim.log
	grep -q "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== common/frontend_pkg.sv ====
`default_nettype none

package frontend_pkg;

    localparam int block_inst_size = 8;
    localparam int block_inst_width = 3;
    localparam int vaddr_size = 32;
    localparam int block_size = 32;
    localparam int fsq_width = 4;
    // a slot count needs one bit more than a slot index
    localparam int inst_num_width = block_inst_width + 1;

    // ras action of a branch
    typedef enum logic [2:0] {
        direct,
        push,
        pop,
        pop_push,
        indirect_call
    } br_type_t;

    typedef struct packed {
        logic branch;
        logic direct;
        logic jump;
        br_type_t br_type;
        logic [vaddr_size-1:0] target;
    } predecode_bundle_t;

    // size is the slot index of the predicted-taken branch
    typedef struct packed {
        logic taken;
        logic [block_inst_width-1:0] size;
        logic [vaddr_size-1:0] start_addr;
        logic [vaddr_size-1:0] target;
    } fetch_stream_t;

    typedef struct packed {
        logic [block_inst_size-1:0] en;
        logic [block_inst_size-1:0][31:0] data;
        logic [fsq_width-1:0] fsq_idx;
        fetch_stream_t stream;
        logic exception;
    } fetch_block_t;

    typedef struct packed {
        logic redirect;
        logic ibuf_full;
    } frontend_ctrl_t;

    typedef struct packed {
        logic valid;
        predecode_bundle_t [block_inst_size-1:0] bundles;
        logic [block_inst_size-1:0] en;
        logic [block_inst_size-1:0][31:0] data;
        logic [fsq_width-1:0] fsq_idx;
        fetch_stream_t stream;
        logic ipf;
        logic jump_en;
        logic [block_inst_width-1:0] jump_idx;
    } pd_stage_t;

    typedef struct packed {
        logic en;
        logic [fsq_width-1:0] fsq_idx;
        logic direct;
        br_type_t br_type;
        fetch_stream_t stream;
    } pd_redirect_t;

    typedef struct packed {
        logic [block_inst_size-1:0] en;
        logic [inst_num_width-1:0] num;
        logic [block_inst_size-1:0][31:0] inst;
        logic [fsq_width-1:0] fsq_idx;
        logic ipf;
        logic iam;
    } ibuf_write_t;

endpackage

`default_nettype wire

// ==== design/predecode/inst_predecoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module inst_predecoder (
    input  wire logic [31:0]                    inst,
    input  wire logic [frontend_pkg::vaddr_size-1:0] addr,
    output frontend_pkg::predecode_bundle_t     bundle
);
    import frontend_pkg::*;

    localparam logic [6:0] op_jal = 7'b1101111;
    localparam logic [6:0] op_jalr = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;

    logic [6:0] opcode;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic is_jal;
    logic is_jalr;
    logic is_branch;
    logic rd_link;
    logic rs1_link;
    logic push_valid;
    logic pop_valid;
    logic [vaddr_size-1:0] j_imm;

    assign opcode = inst[6:0];
    assign rd = inst[11:7];
    assign rs1 = inst[19:15];

    assign is_jal = opcode == op_jal;
    assign is_jalr = opcode == op_jalr;
    assign is_branch = opcode == op_branch;

    // x1 and x5 are the link registers
    assign rd_link = (rd == 5'd1) || (rd == 5'd5);
    assign rs1_link = (rs1 == 5'd1) || (rs1 == 5'd5);

    // J-type immediate, sign extended
    assign j_imm = {{(vaddr_size-21){inst[31]}}, inst[31], inst[19:12], inst[20],
                    inst[30:21], 1'b0};

    assign push_valid = (is_jal | is_jalr) & rd_link;
    // a jalr through a link register pops even when rd is also a link
    assign pop_valid = is_jalr & rs1_link;

    always_comb begin
        bundle.branch = is_jal | is_jalr | is_branch;
        // target only meaningful for jal
        bundle.target = addr + j_imm;
        bundle.jump = is_jal;
        // return target comes from the ras, so a popping jalr counts as direct
        bundle.direct = is_jal | pop_valid;
        if (is_jalr && push_valid && !pop_valid) begin
            bundle.br_type = indirect_call;
        end else if (push_valid && pop_valid) begin
            bundle.br_type = pop_push;
        end else if (push_valid) begin
            bundle.br_type = push;
        end else if (pop_valid) begin
            bundle.br_type = pop;
        end else begin
            bundle.br_type = direct;
        end
    end

endmodule

`default_nettype wire

// ==== design/predecode/predecode_check.sv ====
`timescale 1ns/10ps
`default_nettype none

module predecode_check (
    input  wire frontend_pkg::pd_stage_t             stage,
    input  wire frontend_pkg::frontend_ctrl_t        frontend_ctrl,
    input  wire logic [frontend_pkg::vaddr_size-1:0] ras_addr,
    output frontend_pkg::pd_redirect_t               pd_redirect,
    output frontend_pkg::ibuf_write_t                ibuf_write,
    output logic                                     pd_flush
);
    import frontend_pkg::*;

    predecode_bundle_t jump_bundle;
    predecode_bundle_t tail_bundle;
    logic jump_en;
    logic taken;
    logic jump_error;
    logic nobranch_error;
    logic redirect_en;
    logic ras_target;
    logic [vaddr_size-1:0] next_pc;
    logic [block_inst_size-1:0] block_en;
    logic [block_inst_size-1:0] keep_mask;
    logic [inst_num_width-1:0] block_num;

    assign jump_bundle = stage.bundles[stage.jump_idx];
    // slot the predictor claims is taken
    assign tail_bundle = stage.bundles[stage.stream.size];

    assign jump_en = stage.valid & stage.jump_en;
    assign taken = stage.valid & stage.stream.taken;
    assign block_en = stage.valid ? stage.en : '0;
    assign next_pc = stage.stream.start_addr + vaddr_size'(block_size);

    assign jump_error = jump_en & (~stage.stream.taken
                      | (stage.stream.size != stage.jump_idx)
                      | (tail_bundle.jump & (stage.stream.target != tail_bundle.target)));
    assign nobranch_error = taken & ~tail_bundle.branch;
    assign redirect_en = jump_error | nobranch_error;

    assign ras_target = (jump_bundle.br_type == pop) || (jump_bundle.br_type == pop_push);

    always_comb begin
        block_num = '0;
        keep_mask = '0;
        for (int i = 0; i < block_inst_size; i++) begin
            block_num = block_num + inst_num_width'(block_en[i]);
            // slots up to and including the jump
            keep_mask[i] = jump_en & (block_inst_width'(i) <= stage.jump_idx);
        end
    end

    always_comb begin
        // held back while the buffer cannot take the block
        pd_redirect.en = redirect_en & ~frontend_ctrl.ibuf_full;
        pd_redirect.fsq_idx = stage.fsq_idx;
        pd_redirect.direct = jump_en;
        pd_redirect.br_type = jump_en ? jump_bundle.br_type : direct;
        pd_redirect.stream.taken = ~nobranch_error;
        pd_redirect.stream.start_addr = stage.stream.start_addr;
        if (jump_en) begin
            pd_redirect.stream.target = ras_target ? ras_addr : jump_bundle.target;
            pd_redirect.stream.size = stage.jump_idx;
        end else begin
            // fall through to the next block
            pd_redirect.stream.target = next_pc;
            pd_redirect.stream.size = block_inst_width'(block_inst_size - 1);
        end
    end

    assign pd_flush = pd_redirect.en;

    always_comb begin
        ibuf_write.inst = stage.data;
        ibuf_write.fsq_idx = stage.fsq_idx;
        ibuf_write.ipf = stage.ipf;
        ibuf_write.iam = stage.stream.start_addr[1:0] != 2'b00;
        if (pd_redirect.en) begin
            ibuf_write.en = block_en & keep_mask;
            if (jump_en) begin
                ibuf_write.num = inst_num_width'(stage.jump_idx) + inst_num_width'(1);
            end else begin
                ibuf_write.num = '0;
            end
        end else begin
            ibuf_write.en = block_en;
            ibuf_write.num = block_num;
        end
    end

    always_comb begin
        assert final (!(pd_redirect.en && frontend_ctrl.ibuf_full));
        // never write a slot the held block did not enable
        assert final ((ibuf_write.en & ~stage.en) == '0);
    end

endmodule

`default_nettype wire

// ==== design/predecode/predecode_slots.sv ====
`timescale 1ns/10ps
`default_nettype none

module predecode_slots (
    input  wire logic                           clk,
    input  wire logic                           rst,
    input  wire frontend_pkg::fetch_block_t     fetch_block,
    input  wire frontend_pkg::frontend_ctrl_t   frontend_ctrl,
    input  wire logic                           pd_flush,
    output frontend_pkg::pd_stage_t             stage
);
    import frontend_pkg::*;

    predecode_bundle_t [block_inst_size-1:0] bundles;
    logic [block_inst_size-1:0] direct_en;
    logic [block_inst_width-1:0] jump_idx_next;
    logic flush;
    logic load;

    // control state
    logic valid_q;
    logic [block_inst_size-1:0] en_q;
    logic jump_en_q;

    // payload
    predecode_bundle_t [block_inst_size-1:0] bundles_q;
    logic [block_inst_size-1:0][31:0] data_q;
    logic [fsq_width-1:0] fsq_idx_q;
    fetch_stream_t stream_q;
    logic ipf_q;
    logic [block_inst_width-1:0] jump_idx_q;

    for (genvar i = 0; i < block_inst_size; i++) begin : g_slot
        inst_predecoder u_inst_predecoder (
            .inst   (fetch_block.data[i]),
            .addr   (fetch_block.stream.start_addr + vaddr_size'(i * 4)),
            .bundle (bundles[i])
        );
        assign direct_en[i] = fetch_block.en[i] & bundles[i].direct;
    end

    // oldest direct slot wins
    always_comb begin
        jump_idx_next = '0;
        for (int i = block_inst_size - 1; i >= 0; i--) begin
            if (direct_en[i]) begin
                jump_idx_next = block_inst_width'(i);
            end
        end
    end

    assign flush = frontend_ctrl.redirect | pd_flush;
    assign load = ~frontend_ctrl.ibuf_full & ~flush;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_q <= 1'b0;
            en_q <= '0;
            jump_en_q <= 1'b0;
        end else if (flush) begin
            // incoming block is dropped and fetched again
            valid_q <= 1'b0;
            en_q <= '0;
            jump_en_q <= 1'b0;
        end else if (load) begin
            valid_q <= fetch_block.en[0];
            en_q <= fetch_block.en;
            jump_en_q <= |direct_en;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            bundles_q <= bundles;
            data_q <= fetch_block.data;
            fsq_idx_q <= fetch_block.fsq_idx;
            stream_q <= fetch_block.stream;
            ipf_q <= fetch_block.exception;
            jump_idx_q <= jump_idx_next;
        end
    end

    always_comb begin
        stage.valid = valid_q;
        stage.bundles = bundles_q;
        stage.en = en_q;
        stage.data = data_q;
        stage.fsq_idx = fsq_idx_q;
        stage.stream = stream_q;
        stage.ipf = ipf_q;
        stage.jump_en = jump_en_q;
        stage.jump_idx = jump_idx_q;
    end

    // a held block is only valid with its first slot present
    assert property (@(posedge clk) disable iff (!rst) stage.valid |-> stage.en[0]);

endmodule

`default_nettype wire

// ==== design/predecode_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module predecode_top (
    input  wire logic                                clk,
    input  wire logic                                rst,
    input  wire frontend_pkg::fetch_block_t          fetch_block,
    input  wire frontend_pkg::frontend_ctrl_t        frontend_ctrl,
    input  wire logic [frontend_pkg::vaddr_size-1:0] ras_addr,
    output frontend_pkg::pd_redirect_t               pd_redirect,
    output frontend_pkg::ibuf_write_t                ibuf_write
);
    import frontend_pkg::*;

    // stage 1 register contents
    pd_stage_t stage;
    logic pd_flush;

    predecode_slots u_predecode_slots (
        .clk           (clk),
        .rst           (rst),
        .fetch_block   (fetch_block),
        .frontend_ctrl (frontend_ctrl),
        .pd_flush      (pd_flush),
        .stage         (stage)
    );

    // combinational check on the held block
    predecode_check u_predecode_check (
        .stage         (stage),
        .frontend_ctrl (frontend_ctrl),
        .ras_addr      (ras_addr),
        .pd_redirect   (pd_redirect),
        .ibuf_write    (ibuf_write),
        .pd_flush      (pd_flush)
    );

endmodule

`default_nettype wire

// ==== src.f ====
common/frontend_pkg.sv
design/predecode/inst_predecoder.sv
design/predecode/predecode_slots.sv
design/predecode/predecode_check.sv
design/predecode_top.sv
verif/predecode_tb.sv

// ==== verif/predecode_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module predecode_tb;
    import frontend_pkg::*;

    localparam int num_rows = 8;
    localparam int wait_limit = 40;

    logic clk = 1'b0;
    logic rst;
    fetch_block_t fetch_block;
    frontend_ctrl_t frontend_ctrl;
    logic [vaddr_size-1:0] ras_addr;
    pd_redirect_t pd_redirect;
    ibuf_write_t ibuf_write;

    integer seed = 32'hd643;
    int fall_count = 0;
    fetch_block_t idle_block;

    // stimulus and expected values, one entry per test
    string row_name [num_rows];
    fetch_block_t row_block [num_rows];
    logic [vaddr_size-1:0] row_ras [num_rows];
    pd_redirect_t row_redirect [num_rows];
    ibuf_write_t row_ibuf [num_rows];

    predecode_top uut (
        .clk           (clk),
        .rst           (rst),
        .fetch_block   (fetch_block),
        .frontend_ctrl (frontend_ctrl),
        .ras_addr      (ras_addr),
        .pd_redirect   (pd_redirect),
        .ibuf_write    (ibuf_write)
    );

    always #10 clk = ~clk;

    always @(negedge clk) begin
        fall_count <= fall_count + 1;
    end

    task automatic fail_run();
        $display("Finished with errors");
        $fatal(1, "stopped at first error");
    endtask

    // returns just after the next falling edge
    task automatic wait_fall();
        int start;
        int waited;
        start = fall_count;
        waited = 0;
        while (fall_count == start && waited < wait_limit) begin
            #1;
            waited++;
        end
        if (fall_count == start) begin
            $display("timeout: no falling clock edge within %0d ns", wait_limit);
            fail_run();
        end
    endtask

    task automatic compare_redirect(input string name, input pd_redirect_t exp,
                                    input pd_redirect_t act);
        if (act !== exp) begin
            $display("mismatch %s pd_redirect expected %h actual %h", name, exp, act);
            fail_run();
        end
    endtask

    task automatic compare_ibuf(input string name, input ibuf_write_t exp,
                                input ibuf_write_t act);
        if (act !== exp) begin
            $display("mismatch %s ibuf_write expected %h actual %h", name, exp, act);
            fail_run();
        end
    endtask

    // nothing may leave the stage
    task automatic check_quiet(input string name);
        if (pd_redirect.en !== 1'b0 || ibuf_write.en !== '0) begin
            $display("mismatch %s enables expected 0 and 00 actual %b and %h",
                     name, pd_redirect.en, ibuf_write.en);
            fail_run();
        end
    endtask

    // addi with random registers and immediate
    function automatic logic [31:0] filler_word();
        logic [31:0] r;
        r = $random(seed);
        return {r[11:0], r[16:12], 3'b000, r[21:17], 7'b0010011};
    endfunction

    function automatic logic [31:0] jal_word(input logic [4:0] rd, input int offset);
        logic [20:0] imm;
        imm = offset[20:0];
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] jalr_word(input logic [4:0] rd, input logic [4:0] rs1);
        return {12'd0, rs1, 3'b000, rd, 7'b1100111};
    endfunction

    function automatic fetch_block_t make_block(input logic [block_inst_size-1:0] en,
                                                input logic [fsq_width-1:0] fsq,
                                                input logic [vaddr_size-1:0] start,
                                                input logic taken,
                                                input logic [block_inst_width-1:0] size,
                                                input logic [vaddr_size-1:0] target,
                                                input logic exception);
        fetch_block_t b;
        b.en = en;
        for (int i = 0; i < block_inst_size; i++) begin
            b.data[i] = filler_word();
        end
        b.fsq_idx = fsq;
        b.stream.taken = taken;
        b.stream.size = size;
        b.stream.start_addr = start;
        b.stream.target = target;
        b.exception = exception;
        return b;
    endfunction

    function automatic pd_redirect_t exp_redirect(input logic en,
                                                  input logic [fsq_width-1:0] fsq,
                                                  input logic is_direct,
                                                  input br_type_t br,
                                                  input logic taken,
                                                  input logic [block_inst_width-1:0] size,
                                                  input logic [vaddr_size-1:0] start,
                                                  input logic [vaddr_size-1:0] target);
        pd_redirect_t r;
        r.en = en;
        r.fsq_idx = fsq;
        r.direct = is_direct;
        r.br_type = br;
        r.stream.taken = taken;
        r.stream.size = size;
        r.stream.start_addr = start;
        r.stream.target = target;
        return r;
    endfunction

    function automatic ibuf_write_t exp_ibuf(input fetch_block_t b,
                                             input logic [block_inst_size-1:0] en,
                                             input logic [inst_num_width-1:0] num,
                                             input logic iam);
        ibuf_write_t w;
        w.en = en;
        w.num = num;
        w.inst = b.data;
        w.fsq_idx = b.fsq_idx;
        w.ipf = b.exception;
        w.iam = iam;
        return w;
    endfunction

    task automatic build_table();
        fetch_block_t b;
        row_name[0] = "plain_full";
        b = make_block(8'hff, 4'h1, 32'h1000, 1'b0, 3'd0, 32'h0, 1'b0);
        row_block[0] = b;
        row_ras[0] = 32'h0000_9000;
        row_redirect[0] = exp_redirect(1'b0, 4'h1, 1'b0, direct, 1'b1, 3'd7, 32'h1000, 32'h1020);
        row_ibuf[0] = exp_ibuf(b, 8'hff, 4'd8, 1'b0);

        row_name[1] = "plain_partial";
        b = make_block(8'h0f, 4'h2, 32'h2040, 1'b0, 3'd0, 32'h0, 1'b0);
        row_block[1] = b;
        row_ras[1] = 32'h0000_9000;
        row_redirect[1] = exp_redirect(1'b0, 4'h2, 1'b0, direct, 1'b1, 3'd7, 32'h2040, 32'h2060);
        row_ibuf[1] = exp_ibuf(b, 8'h0f, 4'd4, 1'b0);

        // slot 3 at 0x300c jumps forward 0x40
        row_name[2] = "jal_hit";
        b = make_block(8'hff, 4'h3, 32'h3000, 1'b1, 3'd3, 32'h304c, 1'b0);
        b.data[3] = jal_word(5'd0, 32'h40);
        row_block[2] = b;
        row_ras[2] = 32'h0000_9000;
        row_redirect[2] = exp_redirect(1'b0, 4'h3, 1'b1, direct, 1'b1, 3'd3, 32'h3000, 32'h304c);
        row_ibuf[2] = exp_ibuf(b, 8'hff, 4'd8, 1'b0);

        // backward jump from 0x4008
        row_name[3] = "jal_missed";
        b = make_block(8'hff, 4'h4, 32'h4000, 1'b0, 3'd0, 32'h0, 1'b0);
        b.data[2] = jal_word(5'd0, -8);
        row_block[3] = b;
        row_ras[3] = 32'h0000_9000;
        row_redirect[3] = exp_redirect(1'b1, 4'h4, 1'b1, direct, 1'b1, 3'd2, 32'h4000, 32'h4000);
        row_ibuf[3] = exp_ibuf(b, 8'h07, 4'd3, 1'b0);

        // predictor picked the younger jal at slot 5
        row_name[4] = "jal_oldest";
        b = make_block(8'hff, 4'h5, 32'h5000, 1'b1, 3'd5, 32'h5034, 1'b0);
        b.data[1] = jal_word(5'd0, 32'h100);
        b.data[5] = jal_word(5'd0, 32'h20);
        row_block[4] = b;
        row_ras[4] = 32'h0000_9000;
        row_redirect[4] = exp_redirect(1'b1, 4'h5, 1'b1, direct, 1'b1, 3'd1, 32'h5000, 32'h5104);
        row_ibuf[4] = exp_ibuf(b, 8'h03, 4'd2, 1'b0);

        row_name[5] = "nobranch_taken";
        b = make_block(8'hff, 4'h6, 32'h6002, 1'b1, 3'd4, 32'h6100, 1'b1);
        row_block[5] = b;
        row_ras[5] = 32'h0000_9000;
        row_redirect[5] = exp_redirect(1'b1, 4'h6, 1'b0, direct, 1'b0, 3'd7, 32'h6002, 32'h6022);
        row_ibuf[5] = exp_ibuf(b, 8'h00, 4'd0, 1'b1);

        // jalr x0, 0(ra)
        row_name[6] = "ret_pop";
        b = make_block(8'hff, 4'h7, 32'h7000, 1'b0, 3'd0, 32'h0, 1'b0);
        b.data[6] = jalr_word(5'd0, 5'd1);
        row_block[6] = b;
        row_ras[6] = 32'h0008_abc0;
        row_redirect[6] = exp_redirect(1'b1, 4'h7, 1'b1, pop, 1'b1, 3'd6, 32'h7000, 32'h0008_abc0);
        row_ibuf[6] = exp_ibuf(b, 8'h7f, 4'd7, 1'b0);

        // jalr ra, 0(ra)
        row_name[7] = "ret_pop_push";
        b = make_block(8'h3f, 4'h8, 32'h7800, 1'b0, 3'd0, 32'h0, 1'b0);
        b.data[0] = jalr_word(5'd1, 5'd1);
        row_block[7] = b;
        row_ras[7] = 32'h0001_2344;
        row_redirect[7] = exp_redirect(1'b1, 4'h8, 1'b1, pop_push, 1'b1, 3'd0, 32'h7800,
                                       32'h0001_2344);
        row_ibuf[7] = exp_ibuf(b, 8'h01, 4'd1, 1'b0);
    endtask

    initial begin
        pd_redirect_t hold_redirect;
        ibuf_write_t hold_ibuf;
        rst = 1'b0;
        idle_block = '0;
        fetch_block = idle_block;
        frontend_ctrl = '0;
        ras_addr = '0;
        build_table();

        for (int i = 0; i < 5; i++) begin
            wait_fall();
            check_quiet("reset");
        end
        rst = 1'b1;
        wait_fall();
        check_quiet("after_reset");

        for (int i = 0; i < num_rows; i++) begin
            fetch_block = row_block[i];
            ras_addr = row_ras[i];
            wait_fall();
            compare_redirect(row_name[i], row_redirect[i], pd_redirect);
            compare_ibuf(row_name[i], row_ibuf[i], ibuf_write);
            fetch_block = idle_block;
            wait_fall();
            check_quiet({row_name[i], "_drain"});
        end

        // back-pressure on a block that must redirect
        hold_redirect = row_redirect[3];
        hold_redirect.en = 1'b0;
        hold_ibuf = exp_ibuf(row_block[3], 8'hff, 4'd8, 1'b0);
        fetch_block = row_block[3];
        ras_addr = row_ras[3];
        wait_fall();
        frontend_ctrl.ibuf_full = 1'b1;
        fetch_block = idle_block;
        #2;
        compare_redirect("ibuf_full", hold_redirect, pd_redirect);
        compare_ibuf("ibuf_full", hold_ibuf, ibuf_write);
        wait_fall();
        compare_redirect("ibuf_full_hold", hold_redirect, pd_redirect);
        compare_ibuf("ibuf_full_hold", hold_ibuf, ibuf_write);
        frontend_ctrl.ibuf_full = 1'b0;
        #2;
        compare_redirect("ibuf_release", row_redirect[3], pd_redirect);
        compare_ibuf("ibuf_release", row_ibuf[3], ibuf_write);
        wait_fall();
        check_quiet("release_flush");

        // outside flush drops the block that keeps arriving
        fetch_block = row_block[0];
        ras_addr = row_ras[0];
        wait_fall();
        compare_redirect("before_flush", row_redirect[0], pd_redirect);
        compare_ibuf("before_flush", row_ibuf[0], ibuf_write);
        frontend_ctrl.redirect = 1'b1;
        wait_fall();
        frontend_ctrl.redirect = 1'b0;
        fetch_block = idle_block;
        check_quiet("outside_flush");

        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire
